// ==== hdl/frame_extender.sv ====
`timescale 1ns/1ps

module frame_extender #(
  parameter type beat_t = sub_mult_stream_pkg::sample_beat_t
) (
  input  logic  clk,
  input  logic  arst_n,

  // Outside stream
  input  beat_t s_beat,
  input  logic  s_valid,
  output logic  s_ready,

  // Toward the datapath
  output beat_t m_beat,
  output logic  m_valid,
  input  logic  m_ready,

  // Joint frame end from the datapath
  input  logic  frame_done,
  output logic  locked
);

  beat_t buf_s_beat;
  logic  buf_s_valid;
  logic  buf_s_ready;
  beat_t held_beat;
  logic  held_valid;

  // Hold on our last word until all three frames have ended
  assign locked = held_valid & held_beat.last & ~frame_done;

  // While locked the output feeds back into the skid stage.
  // Recirculate only when the held beat is consumed, so a stall
  // never parks a second copy in the skid entry.
  assign buf_s_beat  = locked ? held_beat : s_beat;
  assign buf_s_valid = locked ? m_ready : s_valid;

  // Outside stream is held off for the whole extension
  assign s_ready = locked ? 1'b0 : buf_s_ready;

  skid_buffer #(
    .beat_t (beat_t)
  ) i_skid_buffer (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_beat  (buf_s_beat),
    .s_valid (buf_s_valid),
    .s_ready (buf_s_ready),
    .m_beat  (held_beat),
    .m_valid (held_valid),
    .m_ready (m_ready)
  );

  assign m_beat  = held_beat;
  assign m_valid = held_valid;

endmodule

// ==== hdl/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
  parameter type beat_t = logic
) (
  input  logic  clk,
  input  logic  arst_n,

  // Upstream side
  input  beat_t s_beat,
  input  logic  s_valid,
  output logic  s_ready,

  // Downstream side
  output beat_t m_beat,
  output logic  m_valid,
  input  logic  m_ready
);

  beat_t out_q;
  beat_t skid_q;
  logic  out_valid_q;
  logic  skid_valid_q;
  logic  out_open;

  // Output register may load when it is empty or being drained
  assign out_open = m_ready | ~out_valid_q;

  // Ready straight from a flop, no path from m_ready
  assign s_ready = ~skid_valid_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_open) begin
      // Skid entry drains first, otherwise take the input directly
      out_valid_q  <= skid_valid_q | s_valid;
      skid_valid_q <= 1'b0;
    end else if (s_valid && s_ready) begin
      // Output stalled, park the incoming beat
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_open) begin
      out_q <= skid_valid_q ? skid_q : s_beat;
    end
    // Only the beat taken with the last ready matters
    if (s_ready) begin
      skid_q <= s_beat;
    end
  end

  assign m_beat  = out_q;
  assign m_valid = out_valid_q;

endmodule

// ==== hdl/sub_mult.sv ====
`timescale 1ns/1ps

module sub_mult (
  input  logic                              clk,
  input  logic                              arst_n,

  // Data stream
  input  sub_mult_stream_pkg::sample_beat_t s_data,
  input  logic                              s_data_valid,
  output logic                              s_data_ready,

  // Grid stream
  input  sub_mult_stream_pkg::sample_beat_t s_grid,
  input  logic                              s_grid_valid,
  output logic                              s_grid_ready,

  // Scale stream
  input  sub_mult_stream_pkg::scale_beat_t  s_scale,
  input  logic                              s_scale_valid,
  output logic                              s_scale_ready,

  // Result stream
  output sub_mult_stream_pkg::rslt_beat_t   m_rslt,
  output logic                              m_valid,
  input  logic                              m_ready
);

  import sub_mult_stream_pkg::*;

  sample_beat_t data_beat;
  sample_beat_t grid_beat;
  scale_beat_t  scale_beat;
  logic         data_valid;
  logic         grid_valid;
  logic         scale_valid;
  logic         data_ready;
  logic         grid_ready;
  logic         scale_ready;
  logic         frame_done;

  // Data input stage
  frame_extender #(
    .beat_t (sample_beat_t)
  ) i_data_ext (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_beat     (s_data),
    .s_valid    (s_data_valid),
    .s_ready    (s_data_ready),
    .m_beat     (data_beat),
    .m_valid    (data_valid),
    .m_ready    (data_ready),
    .frame_done (frame_done),
    .locked     ()
  );

  // Grid input stage
  frame_extender #(
    .beat_t (sample_beat_t)
  ) i_grid_ext (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_beat     (s_grid),
    .s_valid    (s_grid_valid),
    .s_ready    (s_grid_ready),
    .m_beat     (grid_beat),
    .m_valid    (grid_valid),
    .m_ready    (grid_ready),
    .frame_done (frame_done),
    .locked     ()
  );

  // Scale input stage
  frame_extender #(
    .beat_t (scale_beat_t)
  ) i_scale_ext (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_beat     (s_scale),
    .s_valid    (s_scale_valid),
    .s_ready    (s_scale_ready),
    .m_beat     (scale_beat),
    .m_valid    (scale_valid),
    .m_ready    (scale_ready),
    .frame_done (frame_done),
    .locked     ()
  );

  sub_mult_datapath i_datapath (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_beat   (data_beat),
    .grid_beat   (grid_beat),
    .scale_beat  (scale_beat),
    .data_valid  (data_valid),
    .grid_valid  (grid_valid),
    .scale_valid (scale_valid),
    .data_ready  (data_ready),
    .grid_ready  (grid_ready),
    .scale_ready (scale_ready),
    .frame_done  (frame_done),
    .m_rslt      (m_rslt),
    .m_valid     (m_valid),
    .m_ready     (m_ready)
  );

endmodule

// ==== hdl/sub_mult_datapath.sv ====
`timescale 1ns/1ps

module sub_mult_datapath (
  input  logic                              clk,
  input  logic                              arst_n,

  // Extender outputs
  input  sub_mult_stream_pkg::sample_beat_t data_beat,
  input  sub_mult_stream_pkg::sample_beat_t grid_beat,
  input  sub_mult_stream_pkg::scale_beat_t  scale_beat,
  input  logic                              data_valid,
  input  logic                              grid_valid,
  input  logic                              scale_valid,
  output logic                              data_ready,
  output logic                              grid_ready,
  output logic                              scale_ready,

  // Pulses on the transfer that closes the joint frame
  output logic                              frame_done,

  // Result stream
  output sub_mult_stream_pkg::rslt_beat_t   m_rslt,
  output logic                              m_valid,
  input  logic                              m_ready
);

  import sub_mult_fmt_pkg::*;
  import sub_mult_stream_pkg::*;

  logic                       all_valid;
  logic                       out_ready;
  logic                       join_fire;
  logic                       last_all;
  logic signed [SAMPLE_W-1:0] diff;
  logic signed [PROD_W-1:0]   diff_ext;
  logic signed [PROD_W-1:0]   scale_ext;
  logic signed [PROD_W-1:0]   prod;
  rslt_beat_t                 rslt_beat;

  // Join of the three streams
  assign all_valid = data_valid & grid_valid & scale_valid;
  assign join_fire = all_valid & out_ready;

  // All three are consumed together
  assign data_ready  = join_fire;
  assign grid_ready  = join_fire;
  assign scale_ready = join_fire;

  assign last_all   = data_beat.last & grid_beat.last & scale_beat.last;
  assign frame_done = join_fire & last_all;

  // Difference wraps at the sample width
  assign diff = data_beat.data - grid_beat.data;

  // Sign extend both operands to the full product width
  assign diff_ext  = {{(PROD_W-SAMPLE_W){diff[SAMPLE_W-1]}}, diff};
  assign scale_ext = {{(PROD_W-SCALE_W){scale_beat.scale[SCALE_W-1]}},
                      scale_beat.scale};
  assign prod      = diff_ext * scale_ext;

  // Realign to the result format, high product bits drop off
  assign rslt_beat.data = prod[RSLT_LSB +: RSLT_W];
  assign rslt_beat.last = last_all;

  skid_buffer #(
    .beat_t (rslt_beat_t)
  ) i_out_skid (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_beat  (rslt_beat),
    .s_valid (all_valid),
    .s_ready (out_ready),
    .m_beat  (m_rslt),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

endmodule

// ==== hdl/sub_mult_fmt_pkg.sv ====
package sub_mult_fmt_pkg;

  // Data and grid words, signed with 12 fraction bits
  localparam int SAMPLE_W    = 16;
  localparam int SAMPLE_FRAC = 12;

  // Scale word, signed
  localparam int SCALE_W     = 16;
  localparam int SCALE_FRAC  = 12;

  // Result word as seen on the output stream
  localparam int RSLT_W      = 16;
  localparam int RSLT_FRAC   = 12;

  // Full product width, never narrower than the result itself
  localparam int PROD_W = (RSLT_W > SAMPLE_W + SCALE_W) ?
                          RSLT_W : SAMPLE_W + SCALE_W;

  // Product bit that lines up with the result LSB
  // Product carries SAMPLE_FRAC + SCALE_FRAC fraction bits
  localparam int RSLT_LSB = SAMPLE_FRAC + SCALE_FRAC - RSLT_FRAC;

endpackage

// ==== hdl/sub_mult_stream_pkg.sv ====
package sub_mult_stream_pkg;

  import sub_mult_fmt_pkg::*;

  // Data and grid streams share one beat format
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] data;
    logic                       last;
  } sample_beat_t;

  // Scale stream beat
  typedef struct packed {
    logic signed [SCALE_W-1:0] scale;
    logic                      last;
  } scale_beat_t;

  // Output beat, last is the AND of the three input lasts
  typedef struct packed {
    logic signed [RSLT_W-1:0] data;
    logic                     last;
  } rslt_beat_t;

endpackage

// ==== sub_mult.f ====
hdl/sub_mult_fmt_pkg.sv
hdl/sub_mult_stream_pkg.sv
hdl/skid_buffer.sv
hdl/frame_extender.sv
hdl/sub_mult_datapath.sv
hdl/sub_mult.sv
test/sub_mult_chk.sv
test/sub_mult_tb.sv

// ==== test/sub_mult_chk.sv ====
`timescale 1ns/1ps

module sub_mult_chk (
  input  logic                            clk,
  input  logic                            arst_n,
  input  sub_mult_stream_pkg::rslt_beat_t m_rslt,
  input  logic                            m_valid,
  input  logic                            m_ready
);

  // Count of failed assertions, polled by the testbench
  int fail_count = 0;

  // Output stays idle while reset is held
  reset_idle: assert property (@(posedge clk) !arst_n |-> !m_valid)
    else begin
      fail_count = fail_count + 1;
      $error("m_valid high while arst_n is low");
    end

  // Stalled beat must not change
  stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && !m_ready |=> $stable(m_rslt))
    else begin
      fail_count = fail_count + 1;
      $error("m_rslt changed while m_ready was low");
    end

  // Valid only drops after a transfer
  valid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid)
    else begin
      fail_count = fail_count + 1;
      $error("m_valid fell without a transfer");
    end

endmodule

bind sub_mult sub_mult_chk i_sub_mult_chk (
  .clk     (clk),
  .arst_n  (arst_n),
  .m_rslt  (m_rslt),
  .m_valid (m_valid),
  .m_ready (m_ready)
);

// ==== test/sub_mult_stimulus.txt ====
# Columns: tag, value (hex), last flag (0 or 1)
# Tags: D data, G grid, S scale, E expected result
# Frame 1, equal lengths
D 1000 0
D 0800 0
D 2000 1
G 0400 0
G 0800 0
G 1000 1
S 1000 0
S 2000 0
S 0800 1
E 0c00 0
E 0000 0
E 0800 1
# Frame 2, grid and scale shorter than data
D 1800 0
D 0c00 0
D 0400 0
D f000 1
G 0800 0
G 0400 1
S 2000 1
E 2000 0
E 1000 0
E 0000 0
E d800 1
# Frame 3, grid longest, signed wrap and high bits dropped
D 0400 0
D 8000 1
G 0c00 0
G 7000 0
G 1000 0
G 0000 1
S f000 0
S 7fff 0
S c000 1
E 0800 0
E 7fff 0
E 4000 0
E 0000 1
# Frame 4, scale longest with negative scale
D 0200 1
G 0a00 1
S 3000 0
S e800 1
E e800 0
E 0c00 1
# Frame 5, low product bits dropped
D 0003 0
D fffd 1
G 0000 0
G 0000 1
S 0800 0
S 0800 1
E 0001 0
E fffe 1

// ==== test/sub_mult_tb.sv ====
`timescale 1ns/1ps

module sub_mult_tb;

  import sub_mult_stream_pkg::*;

  localparam int MAX_BEATS  = 256;
  localparam int WAIT_LIMIT = 500;

  logic         clk;
  logic         arst_n;
  sample_beat_t s_data;
  logic         s_data_valid;
  logic         s_data_ready;
  sample_beat_t s_grid;
  logic         s_grid_valid;
  logic         s_grid_ready;
  scale_beat_t  s_scale;
  logic         s_scale_valid;
  logic         s_scale_ready;
  rslt_beat_t   m_rslt;
  logic         m_valid;
  logic         m_ready;

  // Stream 0 is data, 1 is grid, 2 is scale
  logic [16:0]  in_beat [3];
  logic [2:0]   in_valid;
  logic [2:0]   in_ready;

  // Beats per stream and expected results from the data file
  logic [16:0]  stim_mem [3][MAX_BEATS];
  int           stim_len [3];
  logic [16:0]  exp_mem [MAX_BEATS];
  int           exp_len;

  logic         with_stalls;
  logic         checking_done;
  int unsigned  seed;

  assign s_data        = in_beat[0];
  assign s_grid        = in_beat[1];
  assign s_scale       = in_beat[2];
  assign s_data_valid  = in_valid[0];
  assign s_grid_valid  = in_valid[1];
  assign s_scale_valid = in_valid[2];
  assign in_ready      = {s_scale_ready, s_grid_ready, s_data_ready};

  initial clk = 1'b0;
  always #20 clk = ~clk;

  sub_mult i_sub_mult (
    .clk           (clk),
    .arst_n        (arst_n),
    .s_data        (s_data),
    .s_data_valid  (s_data_valid),
    .s_data_ready  (s_data_ready),
    .s_grid        (s_grid),
    .s_grid_valid  (s_grid_valid),
    .s_grid_ready  (s_grid_ready),
    .s_scale       (s_scale),
    .s_scale_valid (s_scale_valid),
    .s_scale_ready (s_scale_ready),
    .m_rslt        (m_rslt),
    .m_valid       (m_valid),
    .m_ready       (m_ready)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Each line holds a tag, a 16-bit hex value and a last flag
  task automatic load_stimulus();
    int               fd;
    int               code;
    int               idx;
    logic [7:0]       tag;
    logic [15:0]      value;
    logic [7:0]       last_flag;
    logic [8*128-1:0] skip_line;
    for (idx = 0; idx < 3; idx++) begin
      stim_len[idx] = 0;
    end
    exp_len = 0;
    fd = $fopen("test/sub_mult_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("could not open test/sub_mult_stimulus.txt");
    end
    code = $fscanf(fd, " %c", tag);
    while (code == 1) begin
      if (tag == "#") begin
        code = $fgets(skip_line, fd);
      end else begin
        code = $fscanf(fd, "%h %h", value, last_flag);
        if (code != 2) begin
          stop_run("malformed line in the stimulus file");
        end
        case (tag)
          "D": idx = 0;
          "G": idx = 1;
          "S": idx = 2;
          "E": idx = 3;
          default: stop_run($sformatf("unknown tag %c in the stimulus file", tag));
        endcase
        if (idx == 3) begin
          exp_mem[exp_len] = {value, last_flag[0]};
          exp_len++;
        end else begin
          stim_mem[idx][stim_len[idx]] = {value, last_flag[0]};
          stim_len[idx]++;
        end
      end
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  // Present each beat until the DUT takes it
  // Random idle gaps only in the stalled pass
  task automatic feed_stream(input int idx);
    int n;
    int gap;
    int waited;
    for (n = 0; n < stim_len[idx]; n++) begin
      gap = with_stalls ? ($urandom % 3) : 0;
      if (gap != 0) begin
        in_valid[idx] = 1'b0;
        repeat (gap) @(negedge clk);
      end
      in_beat[idx]  = stim_mem[idx][n];
      in_valid[idx] = 1'b1;
      waited = 0;
      @(posedge clk);
      while (!in_ready[idx]) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          stop_run($sformatf("timeout: input stream %0d never became ready", idx));
        end
        @(posedge clk);
      end
      @(negedge clk);
    end
    in_valid[idx] = 1'b0;
  endtask

  task automatic drive_ready();
    int cycles;
    cycles = 0;
    while (!checking_done) begin
      cycles++;
      if (cycles > MAX_BEATS * WAIT_LIMIT) begin
        stop_run("timeout: result checking never finished");
      end
      @(negedge clk);
      m_ready = with_stalls ? (($urandom % 4) != 0) : 1'b1;
    end
    m_ready = 1'b1;
  endtask

  task automatic check_results();
    int n;
    int waited;
    for (n = 0; n < exp_len; n++) begin
      waited = 0;
      @(posedge clk);
      while (!(m_valid && m_ready)) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          stop_run($sformatf("timeout: result beat %0d never arrived", n));
        end
        @(posedge clk);
      end
      check_equal($sformatf("m_rslt.data (beat %0d)", n), $unsigned(m_rslt.data),
                  exp_mem[n][16:1]);
      check_equal($sformatf("m_rslt.last (beat %0d)", n), m_rslt.last, exp_mem[n][0]);
    end
    checking_done = 1'b1;
  endtask

  task automatic run_pass(input logic stalls);
    with_stalls   = stalls;
    checking_done = 1'b0;
    fork
      feed_stream(0);
      feed_stream(1);
      feed_stream(2);
      drive_ready();
      check_results();
    join
    // Nothing extra may follow the last frame
    repeat (4) begin
      @(posedge clk);
      check_equal("m_valid", m_valid, 1'b0);
    end
    @(negedge clk);
  endtask

  // Stop at the first assertion failure from the bound checker
  always @(negedge clk) begin
    if (i_sub_mult.i_sub_mult_chk.fail_count != 0) begin
      stop_run("an output handshake assertion failed");
    end
  end

  initial begin
    seed = 32'h7683_a3eb;
    void'($urandom(seed));
    arst_n        = 1'b0;
    m_ready       = 1'b1;
    in_valid      = 3'b000;
    in_beat[0]    = '0;
    in_beat[1]    = '0;
    in_beat[2]    = '0;
    with_stalls   = 1'b0;
    checking_done = 1'b0;
    load_stimulus();
    repeat (8) begin
      @(posedge clk);
      check_equal("m_valid", m_valid, 1'b0);
    end
    @(negedge clk);
    arst_n = 1'b1;
    repeat (2) begin
      @(posedge clk);
      check_equal("m_valid", m_valid, 1'b0);
      check_equal("s_data_ready", s_data_ready, 1'b1);
      check_equal("s_grid_ready", s_grid_ready, 1'b1);
      check_equal("s_scale_ready", s_scale_ready, 1'b1);
    end
    @(negedge clk);
    run_pass(1'b0);
    run_pass(1'b1);
    if (i_sub_mult.i_sub_mult_chk.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("the output checker reported assertion failures");
    end
  end

endmodule
